/* squeeze_pool.f */
logic/squeeze_pkg.sv
logic/sync_fifo.sv
logic/host_pipe.sv
logic/stream_router.sv
logic/op_sequencer.sv
logic/pool_engine.sv
logic/squeeze_top.sv
dv/squeeze_asserts.sv
dv/tb_clock.sv
dv/squeeze_tb.sv

/* Bender.yml */
package:
  name: squeeze_pool

sources:
  - logic/squeeze_pkg.sv
  - logic/sync_fifo.sv
  - logic/host_pipe.sv
  - logic/stream_router.sv
  - logic/op_sequencer.sv
  - logic/pool_engine.sv
  - logic/squeeze_top.sv
  - target: test
    files:
      - dv/squeeze_asserts.sv
      - dv/tb_clock.sv
      - dv/squeeze_tb.sv

/* dv/squeeze_tb.sv */
`timescale 1ns/1ps

module squeeze_tb import squeeze_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000;  // tests take about 500 cycles
	localparam int LOOP_WORDS = 20;

	logic okClk;
	logic rst_n;
	logic in_write;
	word_t in_data;
	logic out_read;
	logic op_en;
	logic in_ready;
	logic out_ready;
	word_t out_data;
	logic out_empty;
	logic op_run;
	logic irq;

	word_t lcg_state = 32'h3e86_d329;
	word_t expect_q[$];                    // expected output words in order
	int cycle_count = 0;
	int irq_count = 0;

	tb_clock clock_inst (
		.okClk (okClk)
	);

	squeeze_top squeeze_top_inst (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.in_write  (in_write),
		.in_data   (in_data),
		.out_read  (out_read),
		.op_en     (op_en),
		.in_ready  (in_ready),
		.out_ready (out_ready),
		.out_data  (out_data),
		.out_empty (out_empty),
		.op_run    (op_run),
		.irq       (irq)
	);

	// ------------------------------------------------
	// helpers
	// ------------------------------------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			abort_run($sformatf("error at %0t: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	function automatic word_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// expected result of one data word
	function automatic word_t pool_ref(input logic [2:0] kind, input word_t w);
		pix_t lo;
		pix_t hi;
		int sum;
		int q;
		lo = w[15:0];
		hi = w[31:16];
		if (kind == OP_MAXPOOL) begin
			q = (int'(lo) > int'(hi)) ? int'(lo) : int'(hi);
		end else begin
			sum = int'(lo) + int'(hi);
			q = sum / 2;                   // rounds toward zero
			if ((sum < 0) && ((sum % 2) != 0)) begin
				q = q - 1;                 // floor for odd negatives
			end
		end
		return {16'h0000, q[15:0]};
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge okClk);
	endtask

	task automatic write_word(input word_t w);
		while (!in_ready) @(negedge okClk);
		in_write = 1'b1;
		in_data = w;
		@(negedge okClk);
		in_write = 1'b0;
	endtask

	task automatic read_word(output word_t w);
		while (out_empty) @(negedge okClk);
		w = out_data;                      // head is stable at the falling edge
		out_read = 1'b1;
		@(negedge okClk);
		out_read = 1'b0;
	endtask

	task automatic check_outputs(input int n);
		word_t got;
		for (int i = 0; i < n; i++) begin
			read_word(got);
			check_value("out_data", got, expect_q.pop_front());
		end
	endtask

	task automatic send_command(input logic [2:0] kind, input op_num_t num);
		write_word({kind, 13'd0, num});
	endtask

	task automatic run_pool(input logic [2:0] kind, input int num);
		word_t w;
		int irq_before;
		irq_before = irq_count;
		send_command(kind, op_num_t'(num));
		while (!op_run) @(negedge okClk);
		for (int i = 0; i < num; i++) begin
			w = next_random();
			expect_q.push_back(pool_ref(kind, w));
			write_word(w);
		end
		check_outputs(num);
		while (irq_count == irq_before) @(negedge okClk);
		wait_cycles(5);
		check_value("irq_count", irq_count, irq_before + 1);
		check_value("op_run", op_run, 1'b0);
	endtask

	// ------------------------------------------------
	// monitors
	// ------------------------------------------------
	always @(negedge okClk) begin
		if (irq) begin
			irq_count++;
		end
		if (squeeze_top_inst.squeeze_asserts_inst.fail_count != 0) begin
			abort_run("a protocol assertion failed");
		end
	end

	always @(posedge okClk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run("timeout: the tests did not finish within the cycle limit");
		end
	end

	// ------------------------------------------------
	// tests
	// ------------------------------------------------
	initial begin
		int written;
		int irq_before;
		word_t w;
		rst_n = 1'b0;
		in_write = 1'b0;
		in_data = '0;
		out_read = 1'b0;
		op_en = 1'b0;
		wait_cycles(5);
		rst_n = 1'b1;
		check_value("op_run", op_run, 1'b0);
		check_value("irq", irq, 1'b0);
		check_value("out_ready", out_ready, 1'b0);
		check_value("out_empty", out_empty, 1'b1);
		check_value("in_ready", in_ready, 1'b0);
		wait_cycles(1);
		check_value("in_ready", in_ready, 1'b1);

		// loopback
		for (int i = 0; i < LOOP_WORDS; i++) begin
			w = next_random();
			expect_q.push_back(w);
			write_word(w);
		end
		check_outputs(LOOP_WORDS);
		wait_cycles(3);
		check_value("out_empty", out_empty, 1'b1);

		// block throttle without reads until in_ready falls
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			if (i == BLOCK_SIZE - 1) begin
				wait_cycles(4);
				check_value("out_ready", out_ready, 1'b0);
			end
			w = next_random();
			expect_q.push_back(w);
			write_word(w);
		end
		wait_cycles(4);
		check_value("out_ready", out_ready, 1'b1);
		written = BLOCK_SIZE;
		while (in_ready) begin
			w = next_random();
			expect_q.push_back(w);
			write_word(w);
			written++;
		end
		assert (written > 2 * PIPE_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE) else begin
			abort_run($sformatf("in_ready fell after only %0d words", written));
		end
		check_outputs(written);
		wait_cycles(3);
		check_value("out_empty", out_empty, 1'b1);

		// pooling operations
		op_en = 1'b1;
		run_pool(OP_MAXPOOL, 12);
		run_pool(OP_AVEPOOL, 10);

		// invalid type is dropped and the next command still runs
		irq_before = irq_count;
		send_command(3'd5, 16'd4);
		for (int i = 0; i < 20; i++) begin
			@(negedge okClk);
			check_value("op_run", op_run, 1'b0);
		end
		check_value("irq_count", irq_count, irq_before);
		run_pool(OP_MAXPOOL, 6);

		wait_cycles(5);
		if (squeeze_top_inst.squeeze_asserts_inst.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run("a protocol assertion failed");
		end
	end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic okClk
);

	initial begin
		okClk = 1'b0;
		forever begin
			#5 okClk = ~okClk;             // 10 ns period
		end
	end

endmodule

/* dv/squeeze_asserts.sv */
`timescale 1ns/1ps

module squeeze_asserts (
	input logic okClk,
	input logic rst_n,
	input logic out_read,
	input logic out_empty,
	input logic op_run,
	input logic irq,
	input logic out_ready
);

	int fail_count = 0;                    // polled by the testbench

	// ------------------------------------------------
	// end of operation
	// ------------------------------------------------
	irq_single_cycle: assert property (
		@(posedge okClk) disable iff (!rst_n) irq |=> !irq
	) else begin
		$error("irq stayed high for more than one cycle");
		fail_count++;
	end

	irq_after_run: assert property (
		@(posedge okClk) disable iff (!rst_n) irq |-> $past(op_run)
	) else begin
		$error("irq rose without op_run high in the cycle before");
		fail_count++;
	end

	// ------------------------------------------------
	// reset and host side
	// ------------------------------------------------
	quiet_in_reset: assert property (
		@(posedge okClk) !rst_n |-> (!op_run && !out_ready)
	) else begin
		$error("op_run or out_ready high during reset");
		fail_count++;
	end

	read_not_empty: assert property (
		@(posedge okClk) disable iff (!rst_n) out_read |-> !out_empty
	) else begin
		$error("out_read strobed while the output pipe was empty");
		fail_count++;
	end

endmodule

bind squeeze_top squeeze_asserts squeeze_asserts_inst (
	.okClk     (okClk),
	.rst_n     (rst_n),
	.out_read  (out_read),
	.out_empty (out_empty),
	.op_run    (op_run),
	.irq       (irq),
	.out_ready (out_ready)
);

/* logic/squeeze_top.sv */
`timescale 1ns/1ps

module squeeze_top import squeeze_pkg::*; (
	input  logic  okClk,
	input  logic  rst_n,
	input  logic  in_write,
	input  word_t in_data,
	input  logic  out_read,
	input  logic  op_en,
	output logic  in_ready,
	output logic  out_ready,
	output word_t out_data,
	output logic  out_empty,
	output logic  op_run,
	output logic  irq
);

	// pipe to router
	word_t pipe_in_data;
	logic pipe_in_empty;
	logic pipe_in_pop;
	logic out_we;
	word_t out_wdata;
	logic out_full;

	// router to sequencer and engine
	word_t cmd_word;
	logic cmd_empty;
	logic cmd_pop;
	word_t data_word;
	logic data_empty;
	logic data_pop;
	logic res_we;
	word_t res_word;

	// sequencer to engine
	logic start;
	op_type_e op_type;
	op_num_t op_num;
	logic done;

	host_pipe host_pipe_inst (
		.okClk         (okClk),
		.rst_n         (rst_n),
		.in_write      (in_write),
		.in_data       (in_data),
		.pipe_in_pop   (pipe_in_pop),
		.pipe_in_data  (pipe_in_data),
		.pipe_in_empty (pipe_in_empty),
		.out_we        (out_we),
		.out_wdata     (out_wdata),
		.out_full      (out_full),
		.out_read      (out_read),
		.out_data      (out_data),
		.out_empty     (out_empty),
		.in_ready      (in_ready),
		.out_ready     (out_ready)
	);

	stream_router stream_router_inst (
		.okClk         (okClk),
		.rst_n         (rst_n),
		.op_en         (op_en),
		.op_run        (op_run),
		.pipe_in_data  (pipe_in_data),
		.pipe_in_empty (pipe_in_empty),
		.out_full      (out_full),
		.cmd_pop       (cmd_pop),
		.data_pop      (data_pop),
		.res_we        (res_we),
		.res_word      (res_word),
		.pipe_in_pop   (pipe_in_pop),
		.out_we        (out_we),
		.out_wdata     (out_wdata),
		.cmd_word      (cmd_word),
		.cmd_empty     (cmd_empty),
		.data_word     (data_word),
		.data_empty    (data_empty)
	);

	op_sequencer op_sequencer_inst (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.op_en     (op_en),
		.cmd_word  (cmd_word),
		.cmd_empty (cmd_empty),
		.done      (done),
		.cmd_pop   (cmd_pop),
		.start     (start),
		.op_type   (op_type),
		.op_num    (op_num),
		.op_run    (op_run),
		.irq       (irq)
	);

	pool_engine pool_engine_inst (
		.okClk      (okClk),
		.rst_n      (rst_n),
		.start      (start),
		.op_type    (op_type),
		.op_num     (op_num),
		.data_word  (data_word),
		.data_empty (data_empty),
		.out_full   (out_full),
		.data_pop   (data_pop),
		.res_we     (res_we),
		.res_word   (res_word),
		.done       (done)
	);

endmodule

/* logic/pool_engine.sv */
`timescale 1ns/1ps

module pool_engine import squeeze_pkg::*; (
	input  logic     okClk,
	input  logic     rst_n,
	input  logic     start,
	input  op_type_e op_type,
	input  op_num_t  op_num,
	input  word_t    data_word,
	input  logic     data_empty,
	input  logic     out_full,
	output logic     data_pop,
	output logic     res_we,
	output word_t    res_word,
	output logic     done
);

	op_type_e kind;                        // latched on start
	op_num_t remain;                       // words still to pop
	logic last_wr;                         // marks the final result write
	pix_t lo_pix;
	pix_t hi_pix;
	pix_t max_pix;
	pix_t ave_pix;
	pix_t pool_pix;
	logic signed [16:0] pair_sum;
	logic signed [16:0] pair_half;

	assign data_pop = (remain != '0) && !data_empty && !out_full;

	// ------------------------------------------------
	// datapath
	// ------------------------------------------------
	assign lo_pix = data_word[15:0];
	assign hi_pix = data_word[31:16];
	assign max_pix = (lo_pix > hi_pix) ? lo_pix : hi_pix;   // signed compare
	assign pair_sum = {lo_pix[15], lo_pix} + {hi_pix[15], hi_pix};
	assign pair_half = pair_sum >>> 1;     // floor of sum / 2
	assign ave_pix = pair_half[15:0];
	assign pool_pix = (kind == OP_AVEPOOL) ? ave_pix : max_pix;

	always_ff @(posedge okClk) begin
		if (data_pop) begin
			res_word <= {16'h0000, pool_pix};
		end
	end

	// ------------------------------------------------
	// control
	// ------------------------------------------------
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			kind <= OP_NONE;
			remain <= '0;
			last_wr <= 1'b0;
			res_we <= 1'b0;
			done <= 1'b0;
		end else begin
			if (start) begin
				kind <= op_type;
				remain <= op_num;
			end else if (data_pop) begin
				remain <= remain - 1'b1;
			end
			res_we <= data_pop;            // result lands one cycle later
			last_wr <= data_pop && (remain == op_num_t'(1));
			done <= last_wr;
		end
	end

endmodule

/* logic/op_sequencer.sv */
`timescale 1ns/1ps

module op_sequencer import squeeze_pkg::*; (
	input  logic     okClk,
	input  logic     rst_n,
	input  logic     op_en,
	input  word_t    cmd_word,
	input  logic     cmd_empty,
	input  logic     done,
	output logic     cmd_pop,
	output logic     start,
	output op_type_e op_type,
	output op_num_t  op_num,
	output logic     op_run,
	output logic     irq
);

	seq_state_e state;
	logic [2:0] cmd_type_q;                // fields of the popped command
	op_num_t cmd_num_q;
	logic cmd_valid;

	// the fall through head is the command being popped
	assign cmd_pop = (state == SEQ_IDLE) && op_en && !cmd_empty;

	// only the two pooling kinds run and never with zero words
	assign cmd_valid = ((cmd_type_q == OP_MAXPOOL) || (cmd_type_q == OP_AVEPOOL)) &&
		(cmd_num_q != '0);

	always_ff @(posedge okClk) begin
		if (cmd_pop) begin
			cmd_type_q <= cmd_word[OP_TYPE_MSB:OP_TYPE_LSB];
			cmd_num_q <= cmd_word[OP_NUM_MSB:OP_NUM_LSB];
		end
	end

	// ------------------------------------------------
	// fetch, decode, run
	// ------------------------------------------------
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			start <= 1'b0;
			op_run <= 1'b0;
			irq <= 1'b0;
			op_type <= OP_NONE;
			op_num <= '0;
		end else begin
			start <= 1'b0;                 // strobes by default
			irq <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (cmd_pop) begin
						state <= SEQ_FETCH;
					end
				end
				SEQ_FETCH: begin
					if (cmd_valid) begin
						op_type <= op_type_e'(cmd_type_q);
						op_num <= cmd_num_q;
						start <= 1'b1;     // same cycle as op_run rises
						op_run <= 1'b1;
						state <= SEQ_RUN;
					end else begin
						state <= SEQ_IDLE; // invalid command dropped
					end
				end
				SEQ_RUN: begin
					if (done) begin
						op_run <= 1'b0;
						irq <= 1'b1;
						state <= SEQ_DONE;
					end
				end
				SEQ_DONE: begin
					state <= SEQ_IDLE;     // irq drops here
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

/* logic/stream_router.sv */
`timescale 1ns/1ps

module stream_router import squeeze_pkg::*; (
	input  logic  okClk,
	input  logic  rst_n,
	input  logic  op_en,
	input  logic  op_run,
	input  word_t pipe_in_data,
	input  logic  pipe_in_empty,
	input  logic  out_full,
	input  logic  cmd_pop,
	input  logic  data_pop,
	input  logic  res_we,
	input  word_t res_word,
	output logic  pipe_in_pop,
	output logic  out_we,
	output word_t out_wdata,
	output word_t cmd_word,
	output logic  cmd_empty,
	output word_t data_word,
	output logic  data_empty
);

	logic cmd_full;
	logic data_full;
	logic dest_room;
	logic cmd_we;
	logic data_we;

	// destination is loopback, command or data
	assign dest_room = !op_en ? !out_full :
		(op_run ? !data_full : !cmd_full);
	assign pipe_in_pop = !pipe_in_empty && dest_room;   // one word per cycle
	assign cmd_we = pipe_in_pop && op_en && !op_run;
	assign data_we = pipe_in_pop && op_en && op_run;

	// engine results own the output fifo in op mode
	assign out_we = op_en ? res_we : pipe_in_pop;
	assign out_wdata = op_en ? res_word : pipe_in_data;

	sync_fifo #(
		.DEPTH(CMD_DEPTH)
	) cmd_fifo (
		.okClk   (okClk),
		.rst_n   (rst_n),
		.wr_en   (cmd_we),
		.wr_data (pipe_in_data),
		.rd_en   (cmd_pop),
		.rd_data (cmd_word),
		.empty   (cmd_empty),
		.full    (cmd_full),
		.count   ()
	);

	sync_fifo #(
		.DEPTH(DATA_DEPTH)
	) data_fifo (
		.okClk   (okClk),
		.rst_n   (rst_n),
		.wr_en   (data_we),
		.wr_data (pipe_in_data),
		.rd_en   (data_pop),
		.rd_data (data_word),
		.empty   (data_empty),
		.full    (data_full),
		.count   ()
	);

endmodule

/* logic/host_pipe.sv */
`timescale 1ns/1ps

module host_pipe import squeeze_pkg::*; (
	input  logic  okClk,
	input  logic  rst_n,
	// host side of the input pipe
	input  logic  in_write,
	input  word_t in_data,
	// router side
	input  logic  pipe_in_pop,
	output word_t pipe_in_data,
	output logic  pipe_in_empty,
	input  logic  out_we,
	input  word_t out_wdata,
	output logic  out_full,
	// host side of the output pipe
	input  logic  out_read,
	output word_t out_data,
	output logic  out_empty,
	output logic  in_ready,
	output logic  out_ready
);

	count_t in_count;
	count_t out_count;

	// ------------------------------------------------
	// pipe buffers
	// ------------------------------------------------
	sync_fifo #(
		.DEPTH(PIPE_DEPTH)
	) in_fifo (
		.okClk   (okClk),
		.rst_n   (rst_n),
		.wr_en   (in_write),
		.wr_data (in_data),
		.rd_en   (pipe_in_pop),
		.rd_data (pipe_in_data),
		.empty   (pipe_in_empty),
		.full    (),                   // host obeys in_ready
		.count   (in_count)
	);

	sync_fifo #(
		.DEPTH(PIPE_DEPTH)
	) out_fifo (
		.okClk   (okClk),
		.rst_n   (rst_n),
		.wr_en   (out_we),
		.wr_data (out_wdata),
		.rd_en   (out_read),
		.rd_data (out_data),
		.empty   (out_empty),
		.full    (out_full),
		.count   (out_count)
	);

	// ------------------------------------------------
	// block throttle
	// ------------------------------------------------
	// The host moves whole blocks, so in_ready asks for room for a full
	// block plus headroom, since the flag trails the count by a cycle.
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			in_ready <= 1'b0;
			out_ready <= 1'b0;
		end else begin
			in_ready <= (in_count <=
				count_t'(PIPE_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE));
			out_ready <= (out_count >= count_t'(BLOCK_SIZE)); // one block to read
		end
	end

endmodule

/* logic/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo import squeeze_pkg::*; #(
	parameter int DEPTH = PIPE_DEPTH
) (
	input  logic   okClk,
	input  logic   rst_n,
	input  logic   wr_en,
	input  word_t  wr_data,
	input  logic   rd_en,
	output word_t  rd_data,
	output logic   empty,
	output logic   full,
	output count_t count
);

	word_t mem [DEPTH];                    // storage words
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign full = (count == count_t'(DEPTH));
	assign do_wr = wr_en & ~full;          // write into a full fifo is dropped
	assign do_rd = rd_en & ~empty;

	// first word fall through
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge okClk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;   // wraps on a power of two depth
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* logic/squeeze_pkg.sv */
package squeeze_pkg;

	// ------------------------------------------------
	// data widths
	// ------------------------------------------------
	typedef logic [31:0] word_t;           // one pipe word
	typedef logic signed [15:0] pix_t;     // half of a data word
	typedef logic [6:0] count_t;           // fifo occupancy up to 64
	typedef logic [15:0] op_num_t;         // words per operation

	// fifo sizes and host block throttle
	localparam int PIPE_DEPTH      = 64;
	localparam int CMD_DEPTH       = 16;
	localparam int DATA_DEPTH      = 32;
	localparam int BLOCK_SIZE      = 8;
	localparam int BUFFER_HEADROOM = 4;    // slack for the registered ready flags

	// ------------------------------------------------
	// command word layout
	// ------------------------------------------------
	localparam int OP_TYPE_MSB = 31;
	localparam int OP_TYPE_LSB = 29;
	localparam int OP_NUM_MSB  = 15;
	localparam int OP_NUM_LSB  = 0;

	typedef enum logic [2:0] {
		OP_NONE    = 3'd0,
		OP_MAXPOOL = 3'd1,
		OP_AVEPOOL = 3'd2
	} op_type_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_RUN,
		SEQ_DONE
	} seq_state_e;

endpackage
